// File: design/ex_pkg.sv
// Shared types and constants for the RV32IM execute stage; imported by every design module.
package ex_pkg;

    // Data path width.
    localparam int xlen = 32;

    // Iterations of the multiply/divide unit, one result bit each.
    localparam int md_steps = 32;

    // Major opcodes handled by this stage.
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;

    // Funct7 values.
    // Alternate form selects sub and sra.
    localparam logic [6:0] funct7_alt    = 7'b0100000;
    localparam logic [6:0] funct7_muldiv = 7'b0000001;

    // Trap cause raised for an unknown or malformed instruction.
    localparam logic [3:0] cause_illegal = 4'd2;

    // Single-cycle ALU operations.
    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,
        alu_sltu   = 4'd4,
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        // Operand b straight through, for lui.
        alu_pass_b = 4'd10
    } alu_op_t;

    // M extension operations, value equals funct3.
    typedef enum logic [2:0] {
        md_mul    = 3'd0,
        md_mulh   = 3'd1,
        md_mulhsu = 3'd2,
        md_mulhu  = 3'd3,
        md_div    = 3'd4,
        md_divu   = 3'd5,
        md_rem    = 3'd6,
        md_remu   = 3'd7
    } md_op_t;

    // Multiply/divide unit FSM.
    typedef enum logic [1:0] {
        md_idle = 2'd0,
        md_run  = 2'd1,
        // Sign and special case correction.
        md_fix  = 2'd2,
        // Result held, md_ack high.
        md_done = 2'd3
    } md_state_t;

endpackage

// File: design/ex_decode.sv
// Combinational decoder of the execute stage; maps an instruction word to ALU or M-unit controls.
module ex_decode (
    input  logic [31:0]     insn,
    output ex_pkg::alu_op_t alu_op,
    output ex_pkg::md_op_t  md_op,
    output logic            is_md,
    output logic            use_imm,
    output logic            use_pc,
    output logic [31:0]     imm,
    output logic            illegal
);
    import ex_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [31:0] imm_i;
    logic [31:0] imm_u;

    // Plain operation for each funct3 of the OP and OP-IMM groups.
    function automatic alu_op_t base_op(input logic [2:0] f3);
        case (f3)
            3'd0:    return alu_add;
            3'd1:    return alu_sll;
            3'd2:    return alu_slt;
            3'd3:    return alu_sltu;
            3'd4:    return alu_xor;
            3'd5:    return alu_srl;
            3'd6:    return alu_or;
            default: return alu_and;
        endcase
    endfunction

    assign opcode = insn[6:0];
    assign funct3 = insn[14:12];
    assign funct7 = insn[31:25];
    assign imm_i  = {{20{insn[31]}}, insn[31:20]};
    assign imm_u  = {insn[31:12], 12'b0};

    // Funct3 lines up with the M encoding.
    assign md_op = md_op_t'(funct3);

    always_comb begin
        alu_op  = alu_add;
        is_md   = 1'b0;
        use_imm = 1'b0;
        use_pc  = 1'b0;
        imm     = imm_i;
        illegal = 1'b0;
        case (opcode)
            opc_op: begin
                if (funct7 == funct7_muldiv) begin
                    is_md = 1'b1;
                end else if (funct7 == 7'b0) begin
                    alu_op = base_op(funct3);
                end else if (funct7 == funct7_alt && funct3 == 3'd0) begin
                    alu_op = alu_sub;
                end else if (funct7 == funct7_alt && funct3 == 3'd5) begin
                    alu_op = alu_sra;
                end else begin
                    illegal = 1'b1;
                end
            end
            opc_op_imm: begin
                use_imm = 1'b1;
                alu_op  = base_op(funct3);
                // Only the shifts constrain the upper immediate bits.
                if (funct3 == 3'd1 && funct7 != 7'b0) begin
                    illegal = 1'b1;
                end else if (funct3 == 3'd5) begin
                    if (funct7 == funct7_alt) begin
                        alu_op = alu_sra;
                    end else if (funct7 != 7'b0) begin
                        illegal = 1'b1;
                    end
                end
            end
            opc_lui: begin
                use_imm = 1'b1;
                imm     = imm_u;
                alu_op  = alu_pass_b;
            end
            opc_auipc: begin
                use_imm = 1'b1;
                use_pc  = 1'b1;
                imm     = imm_u;
                alu_op  = alu_add;
            end
            default: begin
                illegal = 1'b1;
            end
        endcase
    end

endmodule

// File: design/ex_alu.sv
// Single-cycle integer ALU of the execute stage; one adder, one comparator pair and one shifter.
module ex_alu (
    input  ex_pkg::alu_op_t          op,
    input  logic [ex_pkg::xlen-1:0]  a,
    input  logic [ex_pkg::xlen-1:0]  b,
    output logic [ex_pkg::xlen-1:0]  result
);
    import ex_pkg::*;

    logic            sub_mode;
    logic [xlen:0]   sum;
    logic            lt_s;
    logic            lt_u;
    logic            fill;
    logic [xlen-1:0] sh_in;
    logic [xlen:0]   sh_ext;
    logic [xlen-1:0] sh_out;

    function automatic logic [xlen-1:0] rev(input logic [xlen-1:0] v);
        logic [xlen-1:0] r;
        for (int i = 0; i < xlen; i++) begin
            r[i] = v[xlen-1-i];
        end
        return r;
    endfunction

    // Comparisons reuse the subtractor.
    assign sub_mode = (op == alu_sub) || (op == alu_slt) || (op == alu_sltu);
    assign sum = {1'b0, a} + {1'b0, b ^ {xlen{sub_mode}}} + {{xlen{1'b0}}, sub_mode};

    // No carry out of a - b means a borrow.
    assign lt_u = ~sum[xlen];
    assign lt_s = (a[xlen-1] != b[xlen-1]) ? a[xlen-1] : sum[xlen-1];

    // Left shift is a right shift of the reversed word.
    assign sh_in  = (op == alu_sll) ? rev(a) : a;
    assign fill   = (op == alu_sra) & a[xlen-1];
    assign sh_ext = $signed({fill, sh_in}) >>> b[4:0];
    assign sh_out = (op == alu_sll) ? rev(sh_ext[xlen-1:0]) : sh_ext[xlen-1:0];

    always_comb begin
        case (op)
            alu_add,
            alu_sub:    result = sum[xlen-1:0];
            alu_slt:    result = {{(xlen-1){1'b0}}, lt_s};
            alu_sltu:   result = {{(xlen-1){1'b0}}, lt_u};
            alu_xor:    result = a ^ b;
            alu_or:     result = a | b;
            alu_and:    result = a & b;
            alu_sll,
            alu_srl,
            alu_sra:    result = sh_out;
            alu_pass_b: result = b;
            default:    result = sum[xlen-1:0];
        endcase
    end

endmodule

// File: design/ex_muldiv.sv
// Iterative multiply/divide unit for the M extension; serves one four-phase req/ack request at a time.
module ex_muldiv (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    md_req,
    input  ex_pkg::md_op_t          md_op,
    input  logic [ex_pkg::xlen-1:0] md_a,
    input  logic [ex_pkg::xlen-1:0] md_b,
    output logic                    md_ack,
    output logic [ex_pkg::xlen-1:0] md_result
);
    import ex_pkg::*;

    md_state_t         state;
    logic [5:0]        count;
    md_op_t            op_q;
    logic [2*xlen-1:0] acc;
    logic [xlen-1:0]   mag_b;
    logic [xlen-1:0]   dividend;
    logic              neg_res;
    logic              neg_rem;
    logic              div_zero;
    logic              div_ovf;

    logic              a_signed;
    logic              b_signed;
    logic              neg_a;
    logic              neg_b;
    logic              is_div;
    logic [xlen:0]     add_sum;
    logic [xlen:0]     rem_sh;
    logic [xlen:0]     trial;
    logic [2*xlen-1:0] mul_next;
    logic [2*xlen-1:0] div_next;
    logic [2*xlen-1:0] prod;
    logic [xlen-1:0]   quot;
    logic [xlen-1:0]   rem;
    logic [xlen-1:0]   fixed;

    // Signedness of the incoming request.
    assign a_signed = md_op inside {md_mulh, md_mulhsu, md_div, md_rem};
    assign b_signed = md_op inside {md_mulh, md_div, md_rem};
    assign neg_a    = a_signed & md_a[xlen-1];
    assign neg_b    = b_signed & md_b[xlen-1];
    assign is_div   = op_q[2];

    // Shift-add step: add multiplicand on the low bit, then shift right.
    assign add_sum  = {1'b0, acc[2*xlen-1:xlen]} + (acc[0] ? {1'b0, mag_b} : '0);
    assign mul_next = {add_sum, acc[xlen-1:1]};

    // Restoring step: shift left and keep the difference if it fits.
    assign rem_sh   = acc[2*xlen-1:xlen-1];
    assign trial    = rem_sh - {1'b0, mag_b};
    assign div_next = trial[xlen] ? {rem_sh[xlen-1:0], acc[xlen-2:0], 1'b0}
                                  : {trial[xlen-1:0], acc[xlen-2:0], 1'b1};

    // Sign correction and special cases.
    assign prod = neg_res ? -acc : acc;
    assign quot = neg_res ? -acc[xlen-1:0] : acc[xlen-1:0];
    assign rem  = neg_rem ? -acc[2*xlen-1:xlen] : acc[2*xlen-1:xlen];

    always_comb begin
        case (op_q)
            md_mul:              fixed = prod[xlen-1:0];
            md_mulh,
            md_mulhsu,
            md_mulhu:            fixed = prod[2*xlen-1:xlen];
            md_div,
            md_divu:             fixed = div_zero ? '1 : (div_ovf ? dividend : quot);
            default:             fixed = div_zero ? dividend : (div_ovf ? '0 : rem);
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= md_idle;
            count <= '0;
        end else begin
            case (state)
                md_idle: begin
                    count <= '0;
                    if (md_req) begin
                        state <= md_run;
                    end
                end
                md_run: begin
                    count <= count + 6'd1;
                    if (count == 6'(md_steps - 1)) begin
                        state <= md_fix;
                    end
                end
                md_fix: begin
                    state <= md_done;
                end
                default: begin
                    // Wait for the requester to release.
                    if (!md_req) begin
                        state <= md_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == md_idle && md_req) begin
            op_q     <= md_op;
            acc      <= {{xlen{1'b0}}, neg_a ? -md_a : md_a};
            mag_b    <= neg_b ? -md_b : md_b;
            dividend <= md_a;
            neg_res  <= neg_a ^ neg_b;
            neg_rem  <= neg_a;
            div_zero <= (md_b == '0);
            div_ovf  <= b_signed && md_a == {1'b1, {(xlen-1){1'b0}}} && md_b == '1;
        end else if (state == md_run) begin
            acc <= is_div ? div_next : mul_next;
        end else if (state == md_fix) begin
            md_result <= fixed;
        end
    end

    assign md_ack = (state == md_done);

endmodule

// File: design/ex_stage.sv
// Execute stage top level; computes OP, OP-IMM, LUI, AUIPC and M results into the EX/MEM register.
module ex_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    d_valid,
    input  logic [31:1]             d_pc,
    input  logic [31:0]             d_insn,
    input  logic                    d_use_rd,
    input  logic [ex_pkg::xlen-1:0] d_rs1_val,
    input  logic [ex_pkg::xlen-1:0] d_rs2_val,
    input  logic                    d_trap,
    input  logic [3:0]              d_cause,
    input  logic                    fw_stall_ex,
    input  logic                    fw_stall_mem,
    output logic                    q_valid,
    output logic [31:1]             q_pc,
    output logic [31:0]             q_insn,
    output logic                    q_use_rd,
    output logic [ex_pkg::xlen-1:0] q_rs1_val,
    output logic [ex_pkg::xlen-1:0] q_rs2_val,
    output logic                    q_trap,
    output logic [3:0]              q_cause,
    output logic                    ex_busy
);
    import ex_pkg::*;

    alu_op_t         alu_op;
    md_op_t          dec_md_op;
    logic            is_md;
    logic            use_imm;
    logic            use_pc;
    logic            illegal;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] alu_result;

    logic            md_req;
    logic            md_ack;
    md_op_t          md_op;
    logic [xlen-1:0] md_a;
    logic [xlen-1:0] md_b;
    logic [xlen-1:0] md_result;
    logic [31:1]     hold_pc;
    logic [31:0]     hold_insn;
    logic            hold_use_rd;

    logic            bad;
    logic            accept;
    logic            start_md;
    logic            md_write;

    ex_decode i_ex_decode (
        .insn    (d_insn),
        .alu_op  (alu_op),
        .md_op   (dec_md_op),
        .is_md   (is_md),
        .use_imm (use_imm),
        .use_pc  (use_pc),
        .imm     (imm),
        .illegal (illegal)
    );

    // Auipc takes the pc with bit 0 clear.
    assign op_a = use_pc ? {d_pc, 1'b0} : d_rs1_val;
    assign op_b = use_imm ? imm : d_rs2_val;

    ex_alu i_ex_alu (
        .op     (alu_op),
        .a      (op_a),
        .b      (op_b),
        .result (alu_result)
    );

    ex_muldiv i_ex_muldiv (
        .clk       (clk),
        .rst_n     (rst_n),
        .md_req    (md_req),
        .md_op     (md_op),
        .md_a      (md_a),
        .md_b      (md_b),
        .md_ack    (md_ack),
        .md_result (md_result)
    );

    assign bad      = d_trap | illegal;
    assign accept   = d_valid & ~fw_stall_ex & ~fw_stall_mem & ~ex_busy;
    // Trapped M instructions take the single-cycle path.
    assign start_md = accept & is_md & ~bad;
    assign md_write = md_req & md_ack & ~fw_stall_mem;
    // Busy for exactly as long as a request is open.
    assign ex_busy  = md_req;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_valid <= 1'b0;
            q_trap  <= 1'b0;
            md_req  <= 1'b0;
        end else if (md_req) begin
            if (md_write) begin
                q_valid <= 1'b1;
                q_trap  <= 1'b0;
                md_req  <= 1'b0;
            end
        end else if (!fw_stall_mem) begin
            q_valid <= accept & ~start_md;
            q_trap  <= accept & bad;
            md_req  <= start_md;
        end
    end

    always_ff @(posedge clk) begin
        if (md_write) begin
            q_pc      <= hold_pc;
            q_insn    <= hold_insn;
            q_use_rd  <= hold_use_rd;
            q_rs1_val <= md_result;
            q_rs2_val <= md_b;
            q_cause   <= '0;
        end else if (start_md) begin
            hold_pc     <= d_pc;
            hold_insn   <= d_insn;
            hold_use_rd <= d_use_rd;
            md_op       <= dec_md_op;
            md_a        <= d_rs1_val;
            md_b        <= d_rs2_val;
        end else if (accept) begin
            q_pc      <= d_pc;
            q_insn    <= d_insn;
            // Upstream trap wins over a local illegal.
            q_use_rd  <= d_use_rd & (d_trap | ~illegal);
            q_rs1_val <= bad ? d_rs1_val : alu_result;
            q_rs2_val <= d_rs2_val;
            q_cause   <= d_trap ? d_cause : (illegal ? cause_illegal : 4'd0);
        end
    end

endmodule

// File: test/ex_stage_assert.sv
// Protocol assertions for the execute stage and its M-unit req/ack port; bound into ex_stage.
module ex_stage_assert (
    input logic                clk,
    input logic                rst_n,
    input logic                fw_stall_mem,
    input logic                q_valid,
    input logic [31:1]         q_pc,
    input logic [31:0]         q_insn,
    input logic                q_use_rd,
    input logic [31:0]         q_rs1_val,
    input logic [31:0]         q_rs2_val,
    input logic                q_trap,
    input logic [3:0]          q_cause,
    input logic                ex_busy,
    input logic                md_req,
    input logic                md_ack,
    input ex_pkg::md_op_t      md_op,
    input logic [31:0]         md_a,
    input logic [31:0]         md_b
);
    timeunit 1ns;
    timeprecision 1ps;

    int fails = 0;

    // EX/MEM contents hold while MEM stalls.
    mem_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        q_valid && fw_stall_mem |=> $stable({q_valid, q_pc, q_insn, q_use_rd,
                                             q_rs1_val, q_rs2_val, q_trap, q_cause}))
    else begin
        $error("EX/MEM register changed during a MEM stall");
        fails++;
    end

    // Request and its operands stay put until acknowledged.
    req_held: assert property (@(posedge clk) disable iff (!rst_n)
        md_req && !md_ack |=> md_req && $stable({md_op, md_a, md_b}))
    else begin
        $error("md_req or its operands changed before md_ack");
        fails++;
    end

    ack_held: assert property (@(posedge clk) disable iff (!rst_n)
        md_ack && md_req |=> md_ack)
    else begin
        $error("md_ack dropped while md_req was still high");
        fails++;
    end

    ack_release: assert property (@(posedge clk) disable iff (!rst_n)
        md_ack && !md_req |=> !md_ack)
    else begin
        $error("md_ack stayed high after md_req fell");
        fails++;
    end

    // New request only once the last ack is gone.
    req_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(md_req) |-> !md_ack)
    else begin
        $error("md_req raised while md_ack was still high");
        fails++;
    end

    reset_quiet: assert property (@(posedge clk)
        !rst_n |=> !q_valid && !q_trap && !ex_busy && !md_ack)
    else begin
        $error("Outputs not cleared one cycle into reset");
        fails++;
    end

    busy_no_valid: assert property (@(posedge clk) disable iff (!rst_n)
        ex_busy |-> !q_valid)
    else begin
        $error("q_valid high while ex_busy");
        fails++;
    end

endmodule

bind ex_stage ex_stage_assert i_ex_stage_assert (.*);

// File: test/ex_stage_tb.sv
// Self-checking testbench for the execute stage; random instructions under random stalls.
module ex_stage_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import ex_pkg::*;

    localparam int num_insn    = 320;
    localparam int cycle_limit = 40 * num_insn + 200;

    typedef struct packed {
        logic [31:1] pc;
        logic [31:0] insn;
        logic [31:0] val;
        logic [31:0] rs2;
        logic        use_rd;
        logic        trap;
        logic [3:0]  cause;
    } exp_t;

    logic        clk, rst_n, d_valid, d_use_rd, d_trap, fw_stall_ex, fw_stall_mem;
    logic [31:1] d_pc, q_pc;
    logic [31:0] d_insn, d_rs1_val, d_rs2_val, q_insn, q_rs1_val, q_rs2_val;
    logic [3:0]  d_cause, q_cause;
    logic        q_valid, q_use_rd, q_trap, ex_busy;

    logic [31:0] seed;
    int          errors;
    int          checks;
    int          cycles = 0;
    exp_t        exp_q[$];
    exp_t        pend;
    logic [31:0] p_a;
    logic        p_use_rd, p_trap;
    logic [3:0]  p_cause;

    ex_stage i_ex_stage (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout after %0d cycles, %0d results still outstanding", cycles,
                     exp_q.size());
            $display("Test failures found");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Edge operands three times in eight.
    function automatic logic [31:0] pick_operand();
        logic [31:0] r;
        r = next_rand();
        case (r[31:29])
            3'd0:    return 32'h0;
            3'd1:    return 32'hffff_ffff;
            3'd2:    return 32'h8000_0000;
            default: return next_rand();
        endcase
    endfunction

    // M extension results per the ISA, divide special cases included.
    function automatic logic [31:0] md_model(input logic [2:0] f3, input logic [31:0] a,
                                             input logic [31:0] b);
        logic [63:0]        sa;
        logic [63:0]        ua;
        logic [63:0]        p;
        logic signed [31:0] sq;
        logic signed [31:0] sr;
        logic               ovf;
        sa  = {{32{a[31]}}, a};
        ua  = {32'b0, a};
        ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        sq  = '0;
        sr  = '0;
        if (b != 0 && !ovf) begin
            sq = $signed(a) / $signed(b);
            sr = $signed(a) % $signed(b);
        end
        case (f3)
            3'd1:    p = sa * {{32{b[31]}}, b};
            3'd2:    p = sa * {32'b0, b};
            default: p = ua * {32'b0, b};
        endcase
        case (f3)
            3'd0:             return p[31:0];
            3'd1, 3'd2, 3'd3: return p[63:32];
            3'd4:             return (b == 0) ? 32'hffff_ffff : (ovf ? a : sq);
            3'd5:             return (b == 0) ? 32'hffff_ffff : a / b;
            3'd6:             return (b == 0) ? a : (ovf ? 32'h0 : sr);
            default:          return (b == 0) ? a : a % b;
        endcase
    endfunction

    function automatic logic [31:0] model(input logic [31:0] insn, input logic [31:0] a,
                                          input logic [31:0] b, input logic [31:1] pc);
        logic [31:0] bi;
        logic        is_op;
        is_op = (insn[6:0] == opc_op);
        bi    = is_op ? b : {{20{insn[31]}}, insn[31:20]};
        if (insn[6:0] == opc_lui) return {insn[31:12], 12'b0};
        if (insn[6:0] == opc_auipc) return {pc, 1'b0} + {insn[31:12], 12'b0};
        if (is_op && insn[25]) return md_model(insn[14:12], a, b);
        case (insn[14:12])
            3'd0:    return (is_op && insn[30]) ? a - bi : a + bi;
            3'd1:    return a << bi[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(bi)};
            3'd3:    return {31'b0, a < bi};
            3'd4:    return a ^ bi;
            3'd5: begin
                if (insn[30]) return $signed(a) >>> bi[4:0];
                return a >> bi[4:0];
            end
            3'd6:    return a | bi;
            default: return a & bi;
        endcase
    endfunction

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_output();
        exp_t e;
        if (exp_q.size() == 0) begin
            $display("Result at %0t ns with no instruction outstanding", $time);
            errors++;
        end else begin
            e = exp_q.pop_front();
            checks++;
            compare("q_pc", {e.pc, 1'b0}, {q_pc, 1'b0});
            compare("q_insn", e.insn, q_insn);
            compare("q_use_rd", e.use_rd, q_use_rd);
            compare("q_trap", e.trap, q_trap);
            compare("q_cause", e.cause, q_cause);
            compare("q_rs2_val", e.rs2, q_rs2_val);
            if (!e.trap) begin
                compare("q_rs1_val", e.val, q_rs1_val);
            end
        end
    endtask

    // One falling edge: new stalls, drive the pending instruction, retire what MEM takes.
    task automatic step(input logic want, output logic taken);
        logic [31:0] r;
        @(negedge clk);
        r            = next_rand();
        fw_stall_ex  = (r[31:29] == 3'd0);
        fw_stall_mem = (r[28:26] == 3'd0);
        d_valid      = want;
        d_pc         = pend.pc;
        d_insn       = pend.insn;
        d_use_rd     = p_use_rd;
        d_rs1_val    = p_a;
        d_rs2_val    = pend.rs2;
        d_trap       = p_trap;
        d_cause      = p_cause;
        if (q_valid && !fw_stall_mem) begin
            check_output();
        end
        taken = want && !fw_stall_ex && !fw_stall_mem && !ex_busy;
    endtask

    task automatic make_insn(input int n);
        int          sel;
        int          k;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] r;
        logic [31:0] pcr;
        logic        illegal;
        sel      = n % 32;
        r        = next_rand();
        pcr      = next_rand();
        pend.pc  = pcr[31:1];
        p_a      = pick_operand();
        pend.rs2 = pick_operand();
        p_use_rd = r[16];
        p_trap   = 1'b0;
        p_cause  = 4'd0;
        illegal  = 1'b0;
        if (sel < 19) begin
            // Order add, sub, sll, slt, sltu, xor, srl, sra, or, and; OP-IMM has no sub.
            k  = (sel < 10) ? sel : ((sel == 10) ? 0 : sel - 9);
            f3 = 3'((k < 2) ? 0 : ((k < 7) ? k - 1 : ((k == 7) ? 5 : k - 2)));
            f7 = (k == 1 || k == 7) ? funct7_alt : 7'b0;
            if (sel < 10 || f3 == 3'd1 || f3 == 3'd5) begin
                pend.insn = {f7, r[24:15], f3, r[11:7], ((sel < 10) ? opc_op : opc_op_imm)};
            end else begin
                pend.insn = {r[31:15], f3, r[11:7], opc_op_imm};
            end
        end else if (sel < 21) begin
            pend.insn = {r[31:7], ((sel == 19) ? opc_lui : opc_auipc)};
        end else if (sel < 29) begin
            pend.insn = {funct7_muldiv, r[24:15], 3'(sel - 21), r[11:7], opc_op};
            // First round divides by zero, second hits the signed overflow.
            if (n < 32) begin
                pend.rs2 = 32'h0;
            end else if (n < 64) begin
                p_a      = 32'h8000_0000;
                pend.rs2 = 32'hffff_ffff;
            end
        end else if (sel == 29) begin
            // Trapped M instruction must bypass the unit.
            pend.insn = {funct7_muldiv, r[24:7], opc_op};
            p_trap    = 1'b1;
            p_cause   = r[30:27];
        end else begin
            pend.insn = (sel == 30) ? {r[31:7], 7'b0000011} : {7'b0000010, r[24:7], opc_op};
            illegal   = 1'b1;
        end
        pend.val    = model(pend.insn, p_a, pend.rs2, pend.pc);
        pend.trap   = p_trap | illegal;
        pend.use_rd = p_use_rd & ~illegal;
        pend.cause  = p_trap ? p_cause : (illegal ? 4'd2 : 4'd0);
    endtask

    initial begin
        logic taken;
        seed         = 32'd75049;
        errors       = 0;
        checks       = 0;
        pend         = '0;
        p_a          = '0;
        p_use_rd     = 1'b0;
        p_trap       = 1'b0;
        p_cause      = 4'd0;
        rst_n        = 1'b0;
        d_valid      = 1'b0;
        d_pc         = '0;
        d_insn       = '0;
        d_use_rd     = 1'b0;
        d_rs1_val    = '0;
        d_rs2_val    = '0;
        d_trap       = 1'b0;
        d_cause      = 4'd0;
        fw_stall_ex  = 1'b0;
        fw_stall_mem = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int n = 0; n < num_insn; n++) begin
            make_insn(n);
            taken = 1'b0;
            while (!taken) begin
                step(1'b1, taken);
            end
            exp_q.push_back(pend);
        end
        while (exp_q.size() != 0) begin
            step(1'b0, taken);
        end
        // Idle edges expose duplicated results.
        repeat (8) step(1'b0, taken);
        $display("%0d results checked, %0d errors, %0d assertion failures", checks, errors,
                 i_ex_stage.i_ex_stage_assert.fails);
        if (errors == 0 && i_ex_stage.i_ex_stage_assert.fails == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: ex_stage.f
design/ex_pkg.sv
design/ex_decode.sv
design/ex_alu.sv
design/ex_muldiv.sv
design/ex_stage.sv
test/ex_stage_assert.sv
test/ex_stage_tb.sv
